// File: sources.f
source/bridge_cfg_pkg.sv
source/bridge_pkt_pkg.sv
source/vc_link_if.sv
source/vc_rx_fifo.sv
source/vc_credit_ctrl.sv
source/vc_tx_arbiter.sv
source/vc_rx_demux.sv
source/noc_axis_bridge.sv
dv/tb_clock_gen.sv
dv/noc_axis_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bridge testbench, pass only if the log holds the pass line
verilator --binary --timing --assert -Wno-fatal --top-module noc_axis_bridge_tb \
  -f sources.f -o sim_bin > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_bin > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && exit 0 || exit 1

// File: dv/noc_axis_bridge_tb.sv
/*
  loopback testbench of the NoC to AXI-Stream bridge:
  random NoC traffic, stalled stream loopback, per-channel scoreboard
*/
`default_nettype none

module noc_axis_bridge_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int Depth     = 4;
  localparam int ValidBit  = bridge_cfg_pkg::CreditWidth + 1;
  localparam int RdyRandom = 0;
  localparam int RdyLow    = 1;
  localparam int RdyHigh   = 2;

  logic clk_i;
  logic rst_i;

  // DUT inputs start idle
  logic                         req_valid_i       = 1'b0;
  bridge_pkt_pkg::narrow_data_t req_data_i        = '0;
  logic                         wide_valid_i      = 1'b0;
  bridge_pkt_pkg::wide_data_t   wide_data_i       = '0;
  logic                         req_ready_i       = 1'b0;
  logic                         wide_ready_i      = 1'b0;
  logic                         axis_out_tready_i = 1'b0;
  logic                         axis_in_tvalid_i  = 1'b0;
  bridge_pkt_pkg::tdata_t       axis_in_tdata_i   = '0;
  bridge_pkt_pkg::tuser_t       axis_in_tuser_i   = '0;

  logic                         req_ready_o, wide_ready_o;
  logic                         req_valid_o, wide_valid_o;
  bridge_pkt_pkg::narrow_data_t req_data_o;
  bridge_pkt_pkg::wide_data_t   wide_data_o;
  logic                         axis_out_tvalid_o, axis_in_tready_o;
  bridge_pkt_pkg::tdata_t       axis_out_tdata_o;
  bridge_pkt_pkg::tstrb_t       axis_out_tstrb_o;
  bridge_pkt_pkg::tuser_t       axis_out_tuser_o;

  // traffic control, index 0 is narrow and 1 is wide
  int goal [2];
  int sent [2];
  int send_pct;
  int stall_pct;
  int rdy_mode;

  // scoreboard
  logic [63:0] exp_q [2][$];
  int          acc [2];
  int          data_pkts [2];
  int          delivered [2];
  int          value_errors, protocol_errors, timeout_errors;
  string       test_name;

  // handshakes seen at the falling edge, acted on at the next rising edge
  logic                   in_fire [2] = '{1'b0, 1'b0};
  logic                   lb_fire     = 1'b0;
  bridge_pkt_pkg::tdata_t lb_tdata;
  bridge_pkt_pkg::tuser_t lb_tuser;

  tb_clock_gen #(.ResetCycles(3)) clk_gen_i (.clk_o(clk_i), .rst_o(rst_i));

  noc_axis_bridge #(
    .DepthNarrow ( Depth ),
    .DepthWide   ( Depth )
  ) dut_i (.*);

  ////////////////////////////////////////
  // stimulus and loopback
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (!req_valid_i || in_fire[0]) begin
        req_valid_i <= 1'b0;
        if (sent[0] < goal[0] && $urandom_range(99) < send_pct) begin
          req_valid_i <= 1'b1;
          req_data_i  <= $urandom();
          sent[0]     <= sent[0] + 1;
        end
      end
      if (!wide_valid_i || in_fire[1]) begin
        wide_valid_i <= 1'b0;
        if (sent[1] < goal[1] && $urandom_range(99) < send_pct) begin
          wide_valid_i <= 1'b1;
          wide_data_i  <= {$urandom(), $urandom()};
          sent[1]      <= sent[1] + 1;
        end
      end
      case (rdy_mode)
        RdyLow: begin
          req_ready_i  <= 1'b0;
          wide_ready_i <= 1'b0;
        end
        RdyHigh: begin
          req_ready_i  <= 1'b1;
          wide_ready_i <= 1'b1;
        end
        default: begin
          req_ready_i  <= ($urandom_range(99) < 70);
          wide_ready_i <= ($urandom_range(99) < 70);
        end
      endcase
      // stream loops back one cycle later, unchanged
      axis_out_tready_i <= ($urandom_range(99) >= stall_pct);
      axis_in_tvalid_i  <= lb_fire;
      if (lb_fire) begin
        axis_in_tdata_i <= lb_tdata;
        axis_in_tuser_i <= lb_tuser;
      end
    end
  end

  ////////////////////////////////////////
  // monitor and model
  ////////////////////////////////////////

  function automatic string chan_name(input int ch);
    return (ch == 0) ? "narrow" : "wide";
  endfunction

  task automatic check_delivery(input int ch, input logic fire, input logic [63:0] act);
    logic [63:0] expected;
    if (fire) begin
      delivered[ch]++;
      if (exp_q[ch].size() == 0) begin
        $display("%s: %s flit delivered with nothing outstanding", test_name, chan_name(ch));
        protocol_errors++;
      end else begin
        expected = exp_q[ch].pop_front();
        assert (act == expected) else begin
          $display("ERROR %s: %s flit expected %h actual %h",
                   test_name, chan_name(ch), expected, act);
          value_errors++;
        end
      end
      // credit-only packets never turn into flits
      assert (delivered[ch] <= data_pkts[ch]) else begin
        $display("%s: more %s flits delivered than data packets sent",
                 test_name, chan_name(ch));
        protocol_errors++;
      end
    end
    assert (exp_q[ch].size() <= Depth) else begin
      $display("ERROR %s: %s outstanding flits expected at most %0d actual %0d",
               test_name, chan_name(ch), Depth, exp_q[ch].size());
      value_errors++;
    end
  endtask

  task automatic check_stream();
    bridge_pkt_pkg::tstrb_t strb;
    if (axis_in_tvalid_i) begin
      assert (axis_in_tready_o) else begin
        $display("ERROR %s: axis_in_tready_o expected 1 actual %b",
                 test_name, axis_in_tready_o);
        value_errors++;
      end
    end
    if (lb_fire) begin
      // wide header covers all eight bytes, narrow only the low four
      strb = axis_out_tdata_o[0] ? 8'hFF : 8'h0F;
      assert (axis_out_tstrb_o == strb) else begin
        $display("ERROR %s: tstrb expected %h actual %h", test_name, strb, axis_out_tstrb_o);
        value_errors++;
      end
      if (axis_out_tuser_o[ValidBit]) begin
        data_pkts[axis_out_tdata_o[0]]++;
      end
    end
  endtask

  always @(negedge clk_i) begin
    in_fire[0] = ~rst_i & req_valid_i & req_ready_o;
    in_fire[1] = ~rst_i & wide_valid_i & wide_ready_o;
    lb_fire    = ~rst_i & axis_out_tvalid_o & axis_out_tready_i;
    lb_tdata   = axis_out_tdata_o;
    lb_tuser   = axis_out_tuser_o;
    if (!rst_i) begin
      if (in_fire[0]) begin
        exp_q[0].push_back(64'(req_data_i));
        acc[0]++;
      end
      if (in_fire[1]) begin
        exp_q[1].push_back(wide_data_i);
        acc[1]++;
      end
      check_delivery(0, req_valid_o & req_ready_i, 64'(req_data_o));
      check_delivery(1, wide_valid_o & wide_ready_i, wide_data_o);
      check_stream();
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  // settle after the falling edge so the monitor has already run
  task automatic next_cycle();
    @(negedge clk_i);
    #2;
  endtask

  task automatic start_traffic(input int n, input int pct, input int stall, input int mode);
    goal[0]   += n;
    goal[1]   += n;
    send_pct  = pct;
    stall_pct = stall;
    rdy_mode  = mode;
  endtask

  function automatic bit drained();
    return sent[0] == goal[0] && sent[1] == goal[1] && !req_valid_i && !wide_valid_i &&
           exp_q[0].size() == 0 && exp_q[1].size() == 0;
  endfunction

  task automatic wait_reset(output bit ok);
    int n;
    n = 0;
    next_cycle();
    while (rst_i && n < 10) begin
      next_cycle();
      n++;
    end
    ok = !rst_i;
    if (!ok) begin
      $display("reset was not released within 10 cycles");
      timeout_errors++;
    end
  endtask

  task automatic wait_drained(input int max_cycles, output bit ok);
    int n;
    n = 0;
    while (!drained() && n < max_cycles) begin
      next_cycle();
      n++;
    end
    ok = drained();
    if (!ok) begin
      $display("%s: traffic did not drain within %0d cycles", test_name, max_cycles);
      timeout_errors++;
    end
  endtask

  task automatic wait_accepted(input int t0, input int t1, input int max_cycles,
                               output bit ok);
    int n;
    n = 0;
    while (!(acc[0] >= t0 && acc[1] >= t1) && n < max_cycles) begin
      next_cycle();
      n++;
    end
    ok = acc[0] >= t0 && acc[1] >= t1;
    if (!ok) begin
      $display("%s: burst was not accepted within %0d cycles", test_name, max_cycles);
      timeout_errors++;
    end
  endtask

  task automatic check_outstanding(input int n);
    for (int ch = 0; ch < 2; ch++) begin
      assert (exp_q[ch].size() == n) else begin
        $display("ERROR %s: %s outstanding flits expected %0d actual %0d",
                 test_name, chan_name(ch), n, exp_q[ch].size());
        value_errors++;
      end
    end
  endtask

  task automatic check_packet_totals();
    for (int ch = 0; ch < 2; ch++) begin
      assert (delivered[ch] == data_pkts[ch]) else begin
        $display("ERROR %s: %s delivered flits expected %0d actual %0d",
                 test_name, chan_name(ch), data_pkts[ch], delivered[ch]);
        value_errors++;
      end
    end
  endtask

  task automatic finish_run();
    $display("value errors: %0d, protocol errors: %0d, timeouts: %0d",
             value_errors, protocol_errors, timeout_errors);
    if (value_errors + protocol_errors + timeout_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  initial begin
    int t0;
    int t1;
    bit ok;
    void'($urandom(64));
    test_name = "reset";
    wait_reset(ok);

    if (ok) begin
      test_name = "random_traffic";
      start_traffic(150, 60, 30, RdyRandom);
      wait_drained(4000, ok);
    end

    if (ok) begin
      // blocked outputs, each channel stops at its credit limit
      test_name = "output_backpressure";
      start_traffic(20, 100, 30, RdyLow);
      repeat (60) next_cycle();
      check_outstanding(Depth);
      rdy_mode = RdyRandom;
      wait_drained(1000, ok);
    end

    if (ok) begin
      // outputs stay blocked, so only returned credits can carry the burst
      test_name = "credit_return";
      repeat (20) next_cycle();
      t0 = acc[0] + Depth;
      t1 = acc[1] + Depth;
      start_traffic(Depth, 100, 0, RdyLow);
      wait_accepted(t0, t1, 40, ok);
      if (ok) begin
        check_outstanding(Depth);
        rdy_mode = RdyHigh;
        wait_drained(200, ok);
      end
    end

    if (ok) begin
      check_packet_totals();
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
/*
  testbench clock and synchronous reset generator
*/
`default_nettype none

module tb_clock_gen #(
  parameter int HalfPeriod  = 10,
  parameter int ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // released on a rising edge like any other synchronous input
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: source/noc_axis_bridge.sv
/*
  top level of the NoC to AXI-Stream bridge:
  two credit controllers, transmit arbiter and receive demux
*/
`default_nettype none

module noc_axis_bridge #(
  parameter int DepthNarrow           = bridge_cfg_pkg::DefaultDepthNarrow,
  parameter int DepthWide             = bridge_cfg_pkg::DefaultDepthWide,
  parameter int ForceSendThreshNarrow = DepthNarrow - 1,
  parameter int ForceSendThreshWide   = DepthWide - 1
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  // noc inputs
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  bridge_pkt_pkg::narrow_data_t req_data_i,
  input  logic                         wide_valid_i,
  output logic                         wide_ready_o,
  input  bridge_pkt_pkg::wide_data_t   wide_data_i,
  // noc outputs
  output logic                         req_valid_o,
  input  logic                         req_ready_i,
  output bridge_pkt_pkg::narrow_data_t req_data_o,
  output logic                         wide_valid_o,
  input  logic                         wide_ready_i,
  output bridge_pkt_pkg::wide_data_t   wide_data_o,
  // serial stream
  output logic                         axis_out_tvalid_o,
  input  logic                         axis_out_tready_i,
  output bridge_pkt_pkg::tdata_t       axis_out_tdata_o,
  output bridge_pkt_pkg::tstrb_t       axis_out_tstrb_o,
  output bridge_pkt_pkg::tuser_t       axis_out_tuser_o,
  input  logic                         axis_in_tvalid_i,
  output logic                         axis_in_tready_o,
  input  bridge_pkt_pkg::tdata_t       axis_in_tdata_i,
  input  bridge_pkt_pkg::tuser_t       axis_in_tuser_i
);

  vc_link_if narrow_link ();
  vc_link_if wide_link ();

  logic narrow_credit_valid, wide_credit_valid;
  logic narrow_pop, wide_pop;
  bridge_pkt_pkg::credit_t rx_credit;

  // every delivered flit frees one remote credit
  assign narrow_pop = req_valid_o & req_ready_i;
  assign wide_pop   = wide_valid_o & wide_ready_i;

  vc_credit_ctrl #(
    .data_t          ( bridge_pkt_pkg::narrow_data_t ),
    .Depth           ( DepthNarrow                   ),
    .ForceSendThresh ( ForceSendThreshNarrow         )
  ) i_narrow_ctrl (
    .clk_i, .rst_i,
    .noc_valid_i    ( req_valid_i         ),
    .noc_data_i     ( req_data_i          ),
    .noc_ready_o    ( req_ready_o         ),
    .link           ( narrow_link         ),
    .credit_valid_i ( narrow_credit_valid ),
    .credit_i       ( rx_credit           ),
    .rx_pop_i       ( narrow_pop          )
  );

  vc_credit_ctrl #(
    .data_t          ( bridge_pkt_pkg::wide_data_t ),
    .Depth           ( DepthWide                   ),
    .ForceSendThresh ( ForceSendThreshWide         )
  ) i_wide_ctrl (
    .clk_i, .rst_i,
    .noc_valid_i    ( wide_valid_i      ),
    .noc_data_i     ( wide_data_i       ),
    .noc_ready_o    ( wide_ready_o      ),
    .link           ( wide_link         ),
    .credit_valid_i ( wide_credit_valid ),
    .credit_i       ( rx_credit         ),
    .rx_pop_i       ( wide_pop          )
  );

  vc_tx_arbiter i_tx_arbiter (
    .clk_i, .rst_i,
    .narrow_link, .wide_link,
    .axis_out_tvalid_o, .axis_out_tready_i,
    .axis_out_tdata_o, .axis_out_tstrb_o, .axis_out_tuser_o
  );

  vc_rx_demux #(
    .DepthNarrow ( DepthNarrow ),
    .DepthWide   ( DepthWide   )
  ) i_rx_demux (
    .clk_i, .rst_i,
    .axis_in_tvalid_i, .axis_in_tready_o, .axis_in_tdata_i, .axis_in_tuser_i,
    .narrow_credit_valid_o ( narrow_credit_valid ),
    .wide_credit_valid_o   ( wide_credit_valid   ),
    .credit_o              ( rx_credit           ),
    .req_valid_o, .req_ready_i, .req_data_o,
    .wide_valid_o, .wide_ready_i, .wide_data_o
  );

endmodule

`default_nettype wire

// File: source/vc_rx_demux.sv
/*
  receive side: unpacks the incoming stream, strobes credits to the
  matching controller and pushes data into the per-channel FIFOs
*/
`default_nettype none

module vc_rx_demux #(
  parameter int DepthNarrow = bridge_cfg_pkg::DefaultDepthNarrow,
  parameter int DepthWide   = bridge_cfg_pkg::DefaultDepthWide
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         axis_in_tvalid_i,
  output logic                         axis_in_tready_o,
  input  bridge_pkt_pkg::tdata_t       axis_in_tdata_i,
  input  bridge_pkt_pkg::tuser_t       axis_in_tuser_i,
  output logic                         narrow_credit_valid_o,
  output logic                         wide_credit_valid_o,
  output bridge_pkt_pkg::credit_t      credit_o,
  output logic                         req_valid_o,
  input  logic                         req_ready_i,
  output bridge_pkt_pkg::narrow_data_t req_data_o,
  output logic                         wide_valid_o,
  input  logic                         wide_ready_i,
  output bridge_pkt_pkg::wide_data_t   wide_data_o
);

  localparam int CredW = bridge_cfg_pkg::CreditWidth;

  bridge_pkt_pkg::chan_e      data_hdr, cred_hdr;
  bridge_pkt_pkg::wide_data_t data_field;
  logic is_data, accept;
  logic narrow_push, wide_push, narrow_fifo_ready, wide_fifo_ready;

  // unpack
  assign data_hdr   = bridge_pkt_pkg::chan_e'(axis_in_tdata_i[0]);
  assign data_field = axis_in_tdata_i[bridge_cfg_pkg::WideWidth:1];
  assign is_data    = axis_in_tuser_i[CredW+1];
  assign cred_hdr   = bridge_pkt_pkg::chan_e'(axis_in_tuser_i[CredW]);
  assign credit_o   = axis_in_tuser_i[CredW-1:0];

  assign narrow_push = axis_in_tvalid_i & is_data & (data_hdr == bridge_pkt_pkg::chan_narrow);
  assign wide_push   = axis_in_tvalid_i & is_data & (data_hdr == bridge_pkt_pkg::chan_wide);

  // credit-only packets never wait
  assign axis_in_tready_o = ~is_data |
      ((data_hdr == bridge_pkt_pkg::chan_wide) ? wide_fifo_ready : narrow_fifo_ready);
  assign accept = axis_in_tvalid_i & axis_in_tready_o;

  assign narrow_credit_valid_o = accept & (cred_hdr == bridge_pkt_pkg::chan_narrow);
  assign wide_credit_valid_o   = accept & (cred_hdr == bridge_pkt_pkg::chan_wide);

  vc_rx_fifo #(
    .data_t  ( bridge_pkt_pkg::narrow_data_t ),
    .Depth   ( DepthNarrow                   )
  ) i_narrow_fifo (
    .clk_i   ( clk_i                                      ),
    .rst_i   ( rst_i                                      ),
    .valid_i ( narrow_push                                ),
    .ready_o ( narrow_fifo_ready                          ),
    .data_i  ( data_field[bridge_cfg_pkg::NarrowWidth-1:0] ),
    .valid_o ( req_valid_o                                ),
    .ready_i ( req_ready_i                                ),
    .data_o  ( req_data_o                                 )
  );

  vc_rx_fifo #(
    .data_t  ( bridge_pkt_pkg::wide_data_t ),
    .Depth   ( DepthWide                   )
  ) i_wide_fifo (
    .clk_i   ( clk_i           ),
    .rst_i   ( rst_i           ),
    .valid_i ( wide_push       ),
    .ready_o ( wide_fifo_ready ),
    .data_i  ( data_field      ),
    .valid_o ( wide_valid_o    ),
    .ready_i ( wide_ready_i    ),
    .data_o  ( wide_data_o     )
  );

endmodule

`default_nettype wire

// File: source/vc_tx_arbiter.sv
/*
  transmit side: narrow-priority channel FSM, return credit selection,
  packet packing and the one-entry AXI-Stream output register
*/
`default_nettype none

module vc_tx_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_i,
  vc_link_if.arb                 narrow_link,
  vc_link_if.arb                 wide_link,
  output logic                   axis_out_tvalid_o,
  input  logic                   axis_out_tready_i,
  output bridge_pkt_pkg::tdata_t axis_out_tdata_o,
  output bridge_pkt_pkg::tstrb_t axis_out_tstrb_o,
  output bridge_pkt_pkg::tuser_t axis_out_tuser_o
);

  bridge_pkt_pkg::chan_e      state_q, state_d;
  bridge_pkt_pkg::chan_e      cred_hdr;
  bridge_pkt_pkg::credit_t    cred_cnt;
  bridge_pkt_pkg::wide_data_t sel_data;
  logic sel_valid, sel_is_data, reg_ready, accept;

  // output register
  logic                   tvalid_q;
  bridge_pkt_pkg::tdata_t tdata_q;
  bridge_pkt_pkg::tuser_t tuser_q;

  assign reg_ready = ~tvalid_q | axis_out_tready_i;
  assign accept    = sel_valid & reg_ready;

  ////////////////////////////////////////
  // channel selection
  ////////////////////////////////////////

  always_comb begin
    state_d           = state_q;
    narrow_link.ready = 1'b0;
    wide_link.ready   = 1'b0;
    sel_valid         = narrow_link.valid;
    sel_data          = narrow_link.data;
    sel_is_data       = narrow_link.is_data;
    case (state_q)
      bridge_pkt_pkg::chan_narrow: begin
        narrow_link.ready = reg_ready;
        // wide only gets a turn while narrow has nothing
        if (!narrow_link.valid && wide_link.valid) begin
          state_d = bridge_pkt_pkg::chan_wide;
        end
      end
      bridge_pkt_pkg::chan_wide: begin
        sel_valid       = wide_link.valid;
        sel_data        = wide_link.data;
        sel_is_data     = wide_link.is_data;
        wide_link.ready = reg_ready;
        if (!wide_link.valid || reg_ready) begin
          state_d = bridge_pkt_pkg::chan_narrow;
        end
      end
      default: state_d = bridge_pkt_pkg::chan_narrow;
    endcase
  end

  // piggyback the larger pending count, narrow wins ties
  always_comb begin
    if (wide_link.ret_credits > narrow_link.ret_credits) begin
      cred_hdr = bridge_pkt_pkg::chan_wide;
      cred_cnt = wide_link.ret_credits;
    end else begin
      cred_hdr = bridge_pkt_pkg::chan_narrow;
      cred_cnt = narrow_link.ret_credits;
    end
  end

  assign narrow_link.ret_taken = accept & (cred_hdr == bridge_pkt_pkg::chan_narrow);
  assign wide_link.ret_taken   = accept & (cred_hdr == bridge_pkt_pkg::chan_wide);

  ////////////////////////////////////////
  // output stream register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q  <= bridge_pkt_pkg::chan_narrow;
      tvalid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (reg_ready) begin
        tvalid_q <= sel_valid;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tdata_q <= {sel_data, state_q};
      tuser_q <= {sel_is_data, cred_hdr, cred_cnt};
    end
  end

  assign axis_out_tvalid_o = tvalid_q;
  assign axis_out_tdata_o  = tdata_q;
  assign axis_out_tuser_o  = tuser_q;
  assign axis_out_tstrb_o  =
      (bridge_pkt_pkg::chan_e'(tdata_q[0]) == bridge_pkt_pkg::chan_wide) ?
      bridge_pkt_pkg::WideStrobe : bridge_pkt_pkg::NarrowStrobe;

endmodule

`default_nettype wire

// File: source/vc_credit_ctrl.sv
/*
  per-channel transmit credit counter and pending return-credit counter,
  with force-send of credit-only packets
*/
`default_nettype none

module vc_credit_ctrl #(
  parameter type data_t          = bridge_pkt_pkg::narrow_data_t,
  parameter int  Depth           = bridge_cfg_pkg::DefaultDepthNarrow,
  parameter int  ForceSendThresh = Depth - 1
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    noc_valid_i,
  input  data_t                   noc_data_i,
  output logic                    noc_ready_o,
  vc_link_if.ctrl                 link,
  input  logic                    credit_valid_i,
  input  bridge_pkt_pkg::credit_t credit_i,
  input  logic                    rx_pop_i
);

  bridge_pkt_pkg::credit_t tx_credits_q, tx_credits_d;
  bridge_pkt_pkg::credit_t pending_q, pending_d;
  logic has_credit, flit_avail, force_send, flit_sent;

  assign has_credit = (tx_credits_q != '0);
  assign flit_avail = noc_valid_i & has_credit;

  // credits pile up on an idle channel, so push them out alone
  assign force_send = ~flit_avail & (pending_q != '0) &
                      (pending_q >= bridge_pkt_pkg::credit_t'(ForceSendThresh));

  assign link.valid       = flit_avail | force_send;
  assign link.is_data     = flit_avail;
  assign link.data        = bridge_pkt_pkg::wide_data_t'(noc_data_i);
  assign link.ret_credits = pending_q;

  assign noc_ready_o = has_credit & link.ready;
  assign flit_sent   = noc_valid_i & noc_ready_o;

  always_comb begin
    tx_credits_d = tx_credits_q;
    if (flit_sent) begin
      tx_credits_d = tx_credits_d - 1'b1;
    end
    if (credit_valid_i) begin
      tx_credits_d = tx_credits_d + credit_i;
    end

    pending_d = pending_q;
    // the whole pending count leaves with the packet
    if (link.ret_taken) begin
      pending_d = '0;
    end
    if (rx_pop_i) begin
      pending_d = pending_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tx_credits_q <= bridge_pkt_pkg::credit_t'(Depth);
      pending_q    <= '0;
    end else begin
      tx_credits_q <= tx_credits_d;
      pending_q    <= pending_d;
    end
  end

endmodule

`default_nettype wire

// File: source/vc_rx_fifo.sv
/*
  valid/ready FIFO with a circular buffer and registered full/empty flags
*/
`default_nettype none

module vc_rx_fifo #(
  parameter type data_t = bridge_pkt_pkg::narrow_data_t,
  parameter int  Depth  = bridge_cfg_pkg::DefaultDepthNarrow
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  data_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   count_t;

  data_t  mem_q [Depth];
  ptr_t   wr_ptr_q, rd_ptr_q;
  count_t count_q, count_d;
  logic   full_q, empty_q, push, pop;

  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign ready_o = ~full_q;
  assign valid_o = ~empty_q;
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ~full_q;
  assign pop     = ~empty_q & ready_i;
  assign count_d = count_q + count_t'(push) - count_t'(pop);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_d;
      full_q  <= (count_d == count_t'(Depth));
      empty_q <= (count_d == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: source/vc_link_if.sv
/*
  link between one channel's credit controller and the transmit arbiter
*/
`default_nettype none

interface vc_link_if;

  // flit handshake, data is already zero-extended to the wide width
  logic                       valid;
  logic                       ready;
  bridge_pkt_pkg::wide_data_t data;
  logic                       is_data;

  // return credits offered for piggyback
  bridge_pkt_pkg::credit_t    ret_credits;
  logic                       ret_taken;

  modport ctrl (
    output valid, data, is_data, ret_credits,
    input  ready, ret_taken
  );

  modport arb (
    input  valid, data, is_data, ret_credits,
    output ready, ret_taken
  );

endinterface

`default_nettype wire

// File: source/bridge_pkt_pkg.sv
/*
  serial stream packet layout:
  flit and credit vectors, channel enum, tdata/tuser/tstrb vectors,
  byte strobe patterns for narrow and wide packets
*/
`default_nettype none

package bridge_pkt_pkg;

  typedef logic [bridge_cfg_pkg::NarrowWidth-1:0] narrow_data_t;
  typedef logic [bridge_cfg_pkg::WideWidth-1:0]   wide_data_t;
  typedef logic [bridge_cfg_pkg::CreditWidth-1:0] credit_t;

  // used both as packet header and as arbiter state
  typedef enum logic {
    chan_narrow = 1'b0,
    chan_wide   = 1'b1
  } chan_e;

  // {data field, data channel header}, narrow flits zero-extended
  typedef logic [bridge_cfg_pkg::WideWidth:0] tdata_t;

  // {data validity, credit channel header, credit count}
  typedef logic [bridge_cfg_pkg::CreditWidth+1:0] tuser_t;

  // one strobe bit per byte of the data field
  typedef logic [bridge_cfg_pkg::WideWidth/8-1:0] tstrb_t;

  localparam tstrb_t NarrowStrobe = 8'h0F;
  localparam tstrb_t WideStrobe   = 8'hFF;

endpackage

`default_nettype wire

// File: source/bridge_cfg_pkg.sv
/*
  sizing constants of the bridge:
  flit widths, credit count width and default receive buffer depths
*/
`default_nettype none

package bridge_cfg_pkg;

  // flit widths on the noc side
  localparam int NarrowWidth = 32;
  localparam int WideWidth   = 64;

  // a credit count must hold the largest buffer depth
  localparam int CreditWidth = 4;

  // remote credits and local receive entries per channel
  localparam int DefaultDepthNarrow = 4;
  localparam int DefaultDepthWide   = 4;

endpackage

`default_nettype wire
